/* include/calc_defines.svh */
/*
 * Front-panel build constants
 * Button count, synchronizer depth, debounce length, digit scan period
 */

`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Panel buttons, index 0 is confirm and index 1 is back
`define CALC_NUM_BUTTONS 2

// Flop stages between the raw pins and the clock domain
`define CALC_SYNC_STAGES 2

// Stable cycles before a new button level is accepted
// Short for simulation, a board build raises this
`define CALC_DEBOUNCE_CYCLES 16

// Cycles each seven-segment digit stays enabled
`define CALC_SCAN_CYCLES 64

`endif

/* hdl/calc_mode_pkg.sv */
/*
 * Mode types for the front-panel controller
 * Main mode encoding and the DIP switch code
 */

`default_nettype none

package calc_mode_pkg;

    // ========================================================================
    // Main state
    // ========================================================================
    // Codes 1..5 line up with the switch code that selects them
    typedef enum logic [2:0] {
        MODE_MENU     = 3'd0,
        MODE_INPUT    = 3'd1,
        MODE_GENERATE = 3'd2,
        MODE_DISPLAY  = 3'd3,
        MODE_COMPUTE  = 3'd4,
        MODE_SETTING  = 3'd5
    } main_mode_t;

    // ========================================================================
    // Switch input
    // ========================================================================
    // Raw value of the three DIP switches
    typedef logic [2:0] dip_code_t;

endpackage

`default_nettype wire

/* hdl/calc_display_pkg.sv */
/*
 * Seven-segment display types and helpers
 * Segment pattern, digit select codes, value-to-segment encoder
 */

`default_nettype none

package calc_display_pkg;

    // Active-high segments, bit 0 = a through bit 6 = g
    typedef logic [6:0] seg_pattern_t;

    // One-hot digit enable
    typedef logic [1:0] digit_sel_t;

    // Right digit shows the mode, left digit the switches
    localparam digit_sel_t DIGIT_MODE   = 2'b01;
    localparam digit_sel_t DIGIT_SWITCH = 2'b10;

    // ========================================================================
    // Encoder for the values 0..7
    // ========================================================================
    function automatic seg_pattern_t seg_encode(input logic [2:0] value);
        seg_pattern_t pattern;
        case (value)
            3'd0:    pattern = 7'h3F;
            3'd1:    pattern = 7'h06;
            3'd2:    pattern = 7'h5B;
            3'd3:    pattern = 7'h4F;
            3'd4:    pattern = 7'h66;
            3'd5:    pattern = 7'h6D;
            3'd6:    pattern = 7'h7D;
            default: pattern = 7'h07;
        endcase
        return pattern;
    endfunction

endpackage

`default_nettype wire

/* hdl/button_sync.sv */
/*
 * Multi-stage synchronizer shared by all panel buttons
 */

`timescale 1ns/1ns
`default_nettype none

`include "calc_defines.svh"

module button_sync (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [`CALC_NUM_BUTTONS-1:0] raw,
    output logic [`CALC_NUM_BUTTONS-1:0] synced
);

    // Stage 0 samples the pins, the last stage feeds the debouncers
    logic [`CALC_SYNC_STAGES-1:0][`CALC_NUM_BUTTONS-1:0] sync_q;

    // All buttons shift together so their latency matches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[`CALC_SYNC_STAGES-2:0], raw};
        end
    end

    assign synced = sync_q[`CALC_SYNC_STAGES-1];

endmodule

`default_nettype wire

/* hdl/button_debounce.sv */
/*
 * Debouncer for one synchronized button
 * Stability counter, accepted level, one-cycle press pulse
 */

`timescale 1ns/1ns
`default_nettype none

`include "calc_defines.svh"

module button_debounce (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  level,
    output logic press
);

    localparam int CNT_W = $clog2(`CALC_DEBOUNCE_CYCLES + 1);

    logic             accepted;
    logic [CNT_W-1:0] count;
    logic             differs;
    logic             settle;

    // Input disagrees with what has been accepted so far
    assign differs = (level != accepted);

    // Last disagreeing cycle of a full stable run
    assign settle = differs && (count == CNT_W'(`CALC_DEBOUNCE_CYCLES - 1));

    // ========================================================================
    // Stability counter and accepted level
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accepted <= 1'b0;
            count    <= '0;
        end else if (settle) begin
            accepted <= level;
            count    <= '0;
        end else if (differs) begin
            count <= count + 1'b1;
        end else begin
            // Glitch ended early, start over
            count <= '0;
        end
    end

    // ========================================================================
    // Press pulse
    // ========================================================================
    // Only the 0 to 1 transition counts, release is silent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            press <= 1'b0;
        end else begin
            press <= settle && level;
        end
    end

endmodule

`default_nettype wire

/* hdl/mode_controller.sv */
/*
 * Main menu and mode state machine
 * Confirm selects a mode from the switches, back returns to the menu
 */

`timescale 1ns/1ns
`default_nettype none

module mode_controller (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       confirm,
    input  wire                       back,
    input  wire calc_mode_pkg::dip_code_t dip_sw,
    output calc_mode_pkg::main_mode_t mode
);

    calc_mode_pkg::main_mode_t mode_next;

    // ========================================================================
    // State register
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= calc_mode_pkg::MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        mode_next = mode;
        case (mode)
            calc_mode_pkg::MODE_MENU: begin
                if (confirm) begin
                    case (dip_sw)
                        3'd1:    mode_next = calc_mode_pkg::MODE_INPUT;
                        3'd2:    mode_next = calc_mode_pkg::MODE_GENERATE;
                        3'd3:    mode_next = calc_mode_pkg::MODE_DISPLAY;
                        3'd4:    mode_next = calc_mode_pkg::MODE_COMPUTE;
                        3'd5:    mode_next = calc_mode_pkg::MODE_SETTING;
                        // Unused switch codes keep the menu
                        default: mode_next = calc_mode_pkg::MODE_MENU;
                    endcase
                end
            end

            // Inside any mode, confirm belongs to the (absent) engine
            default: begin
                if (back) begin
                    mode_next = calc_mode_pkg::MODE_MENU;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/status_display.sv */
/*
 * Status display for the front panel
 * Digit scan timer, digit multiplexing, segment encoding, status LEDs
 */

`timescale 1ns/1ns
`default_nettype none

`include "calc_defines.svh"

module status_display (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire calc_mode_pkg::main_mode_t mode,
    input  wire calc_mode_pkg::dip_code_t  dip_sw,
    output calc_display_pkg::seg_pattern_t seg_display,
    output calc_display_pkg::digit_sel_t   seg_select,
    output logic [3:0]                     led_status
);

    localparam int SCAN_W = $clog2(`CALC_SCAN_CYCLES);

    logic [SCAN_W-1:0] scan_count;
    logic              scan_wrap;
    logic [2:0]        mode_code;
    logic              in_mode;

    // ========================================================================
    // Digit scan timer
    // ========================================================================
    assign scan_wrap = (scan_count == SCAN_W'(`CALC_SCAN_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_count <= '0;
        end else if (scan_wrap) begin
            scan_count <= '0;
        end else begin
            scan_count <= scan_count + 1'b1;
        end
    end

    // Rotate the one-hot enable at the end of every period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_select <= calc_display_pkg::DIGIT_MODE;
        end else if (scan_wrap) begin
            seg_select <= {seg_select[0], seg_select[1]};
        end
    end

    // ========================================================================
    // Digit multiplexing and segment encoding
    // ========================================================================
    assign mode_code = mode;

    always_comb begin
        if (seg_select == calc_display_pkg::DIGIT_MODE) begin
            seg_display = calc_display_pkg::seg_encode(mode_code);
        end else begin
            // Switch digit, shows what confirm would select
            seg_display = calc_display_pkg::seg_encode(dip_sw);
        end
    end

    // ========================================================================
    // Status LEDs
    // ========================================================================
    // Top LED lights in every mode except the menu
    assign in_mode    = (mode != calc_mode_pkg::MODE_MENU);
    assign led_status = {in_mode, mode_code};

endmodule

`default_nettype wire

/* hdl/calc_front_panel.sv */
/*
 * Front-panel control path top level
 * Button synchronizer, debouncer array, mode controller, status display
 */

`timescale 1ns/1ns
`default_nettype none

`include "calc_defines.svh"

module calc_front_panel (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire calc_mode_pkg::dip_code_t   dip_sw,
    input  wire                             btn_confirm,
    input  wire                             btn_back,
    output wire calc_display_pkg::seg_pattern_t seg_display,
    output wire calc_display_pkg::digit_sel_t   seg_select,
    output wire [3:0]                       led_status
);

    logic [`CALC_NUM_BUTTONS-1:0] btn_raw;
    logic [`CALC_NUM_BUTTONS-1:0] btn_synced;
    logic [`CALC_NUM_BUTTONS-1:0] btn_press;
    logic                         confirm_pulse;
    logic                         back_pulse;
    calc_mode_pkg::main_mode_t    mode;

    // Bit 0 is confirm, bit 1 is back
    assign btn_raw = {btn_back, btn_confirm};

    // ========================================================================
    // Button input path
    // ========================================================================
    button_sync button_sync_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .raw    (btn_raw),
        .synced (btn_synced)
    );

    for (genvar i = 0; i < `CALC_NUM_BUTTONS; i++) begin : g_debounce
        button_debounce button_debounce_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .level (btn_synced[i]),
            .press (btn_press[i])
        );
    end

    assign confirm_pulse = btn_press[0];
    assign back_pulse    = btn_press[1];

    // ========================================================================
    // Mode control
    // ========================================================================
    mode_controller mode_controller_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .confirm (confirm_pulse),
        .back    (back_pulse),
        .dip_sw  (dip_sw),
        .mode    (mode)
    );

    // ========================================================================
    // Panel outputs
    // ========================================================================
    status_display status_display_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .dip_sw      (dip_sw),
        .seg_display (seg_display),
        .seg_select  (seg_select),
        .led_status  (led_status)
    );

endmodule

`default_nettype wire

/* verification/calc_front_panel_tb.sv */
/*
 * Directed testbench for the front-panel control path
 * Clock, reset, LFSR, compare tasks, test tasks, timeout and verdict
 */

`timescale 1ns/1ns
`default_nettype none

`include "calc_defines.svh"

module calc_front_panel_tb;

    localparam int BTN_CONFIRM    = 0;
    localparam int BTN_BACK       = 1;
    localparam int PRESS_HOLD     = 40;
    localparam int RELEASE_WAIT   = 40;
    // Tests take about 4000 cycles
    localparam int TIMEOUT_CYCLES = 6000;

    localparam calc_display_pkg::digit_sel_t MODE_DIGIT   = 2'b01;
    localparam calc_display_pkg::digit_sel_t SWITCH_DIGIT = 2'b10;

    logic                           clk;
    logic                           rst_n;
    calc_mode_pkg::dip_code_t       dip_sw;
    logic                           btn_confirm;
    logic                           btn_back;
    calc_display_pkg::seg_pattern_t seg_display;
    calc_display_pkg::digit_sel_t   seg_select;
    logic [3:0]                     led_status;

    int          cycle_count  = 0;
    int          mode_changes = 0;
    logic [3:0]  led_prev     = 4'b0000;
    logic [15:0] lfsr_state   = 16'd16029;

    calc_front_panel calc_front_panel_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .dip_sw      (dip_sw),
        .btn_confirm (btn_confirm),
        .btn_back    (btn_back),
        .seg_display (seg_display),
        .seg_select  (seg_select),
        .led_status  (led_status)
    );

    always #4 clk = ~clk;

    // ========================================================================
    // Timeout and LED change monitor
    // ========================================================================
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Test FAILED");
            $fatal(1, "Simulation ran %0d cycles without finishing", cycle_count);
        end
    end

    // Counts every change of the status LEDs after reset
    always @(negedge clk) begin
        if (rst_n && (led_status !== led_prev)) begin
            mode_changes++;
        end
        led_prev <= led_status;
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int width, output int value);
        value = 0;
        for (int b = 0; b < width; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Segment table with bit 0 as segment a
    function automatic calc_display_pkg::seg_pattern_t digit_pattern(input logic [2:0] value);
        logic [6:0] table_rom [8];
        table_rom = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07};
        return table_rom[value];
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_button(input int which, input logic value);
        @(posedge clk);
        #1;
        if (which == BTN_CONFIRM) begin
            btn_confirm = value;
        end else begin
            btn_back = value;
        end
    endtask

    task automatic set_switches(input logic [2:0] code);
        @(posedge clk);
        #1;
        dip_sw = code;
    endtask

    task automatic press_button(input int which, input int hold);
        drive_button(which, 1'b1);
        wait_cycles(hold);
        drive_button(which, 1'b0);
        wait_cycles(RELEASE_WAIT);
    endtask

    // Short excursions away from the idle level that stay under the debounce length
    task automatic glitch_burst(input int which, input logic idle, input int count);
        int len;
        int gap;
        for (int k = 0; k < count; k++) begin
            draw_bits(4, len);
            if (len == 0 || len >= `CALC_DEBOUNCE_CYCLES) begin
                len = 1;
            end
            draw_bits(3, gap);
            drive_button(which, ~idle);
            wait_cycles(len - 1);
            drive_button(which, idle);
            wait_cycles(gap);
        end
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic compare_mode(input calc_mode_pkg::main_mode_t expected);
        logic [2:0] code;
        logic [3:0] expected_leds;
        code          = expected;
        expected_leds = {(code != 3'd0), code};
        @(negedge clk);
        if (led_status !== expected_leds) begin
            report_error($sformatf("led_status is %b, expected %b", led_status, expected_leds));
        end
    endtask

    task automatic compare_segment(input calc_display_pkg::seg_pattern_t expected,
                                   input calc_display_pkg::digit_sel_t digit);
        @(negedge clk);
        while (seg_select !== digit) begin
            @(negedge clk);
        end
        if (seg_display !== expected) begin
            report_error($sformatf("digit %b shows %h, expected %h",
                                   digit, seg_display, expected));
        end
    endtask

    task automatic compare_change_count(input int start, input int expected);
        @(negedge clk);
        if (mode_changes - start != expected) begin
            report_error($sformatf("mode changed %0d times, expected %0d",
                                   mode_changes - start, expected));
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic test_reset_state();
        compare_mode(calc_mode_pkg::MODE_MENU);
        compare_segment(digit_pattern(3'd0), MODE_DIGIT);
    endtask

    task automatic test_mode_entry();
        for (int code = 1; code <= 5; code++) begin
            set_switches(code[2:0]);
            press_button(BTN_CONFIRM, PRESS_HOLD);
            compare_mode(calc_mode_pkg::main_mode_t'(code[2:0]));
            compare_segment(digit_pattern(code[2:0]), MODE_DIGIT);
            press_button(BTN_BACK, PRESS_HOLD);
            compare_mode(calc_mode_pkg::MODE_MENU);
        end
    endtask

    task automatic test_invalid_codes();
        logic [2:0] codes [3];
        codes = '{3'd0, 3'd6, 3'd7};
        foreach (codes[i]) begin
            set_switches(codes[i]);
            press_button(BTN_CONFIRM, PRESS_HOLD);
            compare_mode(calc_mode_pkg::MODE_MENU);
            compare_segment(digit_pattern(codes[i]), SWITCH_DIGIT);
        end
    endtask

    task automatic test_confirm_ignored();
        set_switches(3'd2);
        press_button(BTN_CONFIRM, PRESS_HOLD);
        compare_mode(calc_mode_pkg::MODE_GENERATE);
        set_switches(3'd4);
        press_button(BTN_CONFIRM, PRESS_HOLD);
        compare_mode(calc_mode_pkg::MODE_GENERATE);
        set_switches(3'd1);
        press_button(BTN_CONFIRM, PRESS_HOLD);
        compare_mode(calc_mode_pkg::MODE_GENERATE);
        press_button(BTN_BACK, PRESS_HOLD);
        compare_mode(calc_mode_pkg::MODE_MENU);
    endtask

    task automatic test_glitch_bursts();
        int start;
        set_switches(3'd3);
        start = mode_changes;
        glitch_burst(BTN_CONFIRM, 1'b0, 6);
        glitch_burst(BTN_BACK, 1'b0, 6);
        wait_cycles(RELEASE_WAIT);
        compare_mode(calc_mode_pkg::MODE_MENU);
        compare_change_count(start, 0);

        // Bouncy press and bouncy release of confirm
        glitch_burst(BTN_CONFIRM, 1'b0, 5);
        drive_button(BTN_CONFIRM, 1'b1);
        wait_cycles(PRESS_HOLD);
        glitch_burst(BTN_CONFIRM, 1'b1, 4);
        drive_button(BTN_CONFIRM, 1'b0);
        wait_cycles(RELEASE_WAIT);
        compare_mode(calc_mode_pkg::MODE_DISPLAY);
        compare_change_count(start, 1);

        glitch_burst(BTN_BACK, 1'b0, 4);
        drive_button(BTN_BACK, 1'b1);
        wait_cycles(PRESS_HOLD);
        glitch_burst(BTN_BACK, 1'b1, 4);
        drive_button(BTN_BACK, 1'b0);
        wait_cycles(RELEASE_WAIT);
        compare_mode(calc_mode_pkg::MODE_MENU);
        compare_change_count(start, 2);
    endtask

    task automatic test_long_hold();
        int start;
        set_switches(3'd5);
        start = mode_changes;
        press_button(BTN_CONFIRM, 200);
        compare_mode(calc_mode_pkg::MODE_SETTING);
        compare_change_count(start, 1);
        set_switches(3'd2);
        press_button(BTN_CONFIRM, PRESS_HOLD);
        compare_mode(calc_mode_pkg::MODE_SETTING);
        compare_change_count(start, 1);
        press_button(BTN_BACK, PRESS_HOLD);
        compare_mode(calc_mode_pkg::MODE_MENU);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        dip_sw      = 3'd0;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_mode_entry();
        test_invalid_codes();
        test_confirm_ignored();
        test_glitch_bursts();
        test_long_hold();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/calc_mode_pkg.sv
hdl/calc_display_pkg.sv
hdl/button_sync.sv
hdl/button_debounce.sv
hdl/mode_controller.sv
hdl/status_display.sv
hdl/calc_front_panel.sv
verification/calc_front_panel_tb.sv

/* Bender.yml */
package:
  name: calc_front_panel

sources:
  - include_dirs:
      - include
    files:
      - hdl/calc_mode_pkg.sv
      - hdl/calc_display_pkg.sv
      - hdl/button_sync.sv
      - hdl/button_debounce.sv
      - hdl/mode_controller.sv
      - hdl/status_display.sv
      - hdl/calc_front_panel.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - verification/calc_front_panel_tb.sv
